// File: source/parser_defines.svh
//------------------------------
// uart parser shared macros
// bus address width and the text protocol characters
//------------------------------
`ifndef PARSER_DEFINES_SVH
`define PARSER_DEFINES_SVH

// register file address width, must be a multiple of 4
`define PARSER_ADDR_W	8

// line endings
`define CHAR_CR			8'h0d
`define CHAR_LF			8'h0a

// field separators
`define CHAR_SPACE		8'h20
`define CHAR_TAB		8'h09

// command letters, both cases
`define CHAR_R_UP		8'h52
`define CHAR_R_LO		8'h72
`define CHAR_W_UP		8'h57
`define CHAR_W_LO		8'h77

`endif

// File: source/parser_pkg.sv
//------------------------------
// uart parser types
// widths, state encodings, bus command and hex helpers
//------------------------------
`include "parser_defines.svh"

package parser_pkg;

	// one uart byte
	typedef logic [7:0] char_t;
	// value of one hex digit
	typedef logic [3:0] nibble_t;
	// register file address and data
	typedef logic [`PARSER_ADDR_W-1:0] bus_addr_t;
	typedef logic [7:0] bus_data_t;

	// receive line parser states
	typedef enum logic [2:0] {
		ps_idle,
		ps_white_data,
		ps_data,
		ps_white_addr,
		ps_addr,
		ps_wait_eol
	} parse_state_t;

	// reply transmit states
	typedef enum logic [2:0] {
		tx_idle,
		tx_hi_nib,
		tx_lo_nib,
		tx_cr,
		tx_lf
	} tx_state_t;

	// decoded command handed to the bus sequencer
	typedef struct packed {
		logic		write;
		bus_addr_t	address;
		bus_data_t	data;
	} bus_cmd_t;

	// true for 0-9, A-F and a-f
	function automatic logic is_hex_char(input char_t c);
		return ((c >= 8'h30) && (c <= 8'h39)) ||
			((c >= 8'h41) && (c <= 8'h46)) ||
			((c >= 8'h61) && (c <= 8'h66));
	endfunction

	// low nibble of a letter is 1..6 in either case, so add 9
	function automatic nibble_t hex_to_nibble(input char_t c);
		if (c <= 8'h39)
			return c[3:0];
		else
			return c[3:0] + 4'd9;
	endfunction

	// upper case hex digit, 'A' is 8'h37 + 10
	function automatic char_t nibble_to_hex(input nibble_t n);
		if (n < 4'd10)
			return {4'h3, n};
		else
			return 8'h37 + {4'h0, n};
	endfunction

endpackage

// File: source/command_decoder.sv
//------------------------------
// command decoder
// parses "w DD AA" and "r AA" text lines into bus commands
//------------------------------
`timescale 1ns/1ns
`include "parser_defines.svh"

module command_decoder
(
	input	logic				clock,
	input	logic				reset,
	input	parser_pkg::char_t	rx_data,
	input	logic				new_rx_data,
	output	parser_pkg::bus_cmd_t	cmd,
	output	logic				cmd_valid
);
	import parser_pkg::*;

	parse_state_t	state;
	logic			write_op;
	bus_data_t		data_acc;
	bus_addr_t		addr_acc;

	// byte classification
	logic			is_hex;
	logic			is_eol;
	logic			is_white;
	logic			is_read_cmd;
	logic			is_write_cmd;
	nibble_t		rx_nib;

	assign is_hex = is_hex_char(rx_data);
	assign rx_nib = hex_to_nibble(rx_data);
	assign is_eol = (rx_data == `CHAR_CR) || (rx_data == `CHAR_LF);
	assign is_white = (rx_data == `CHAR_SPACE) || (rx_data == `CHAR_TAB);
	assign is_read_cmd = (rx_data == `CHAR_R_UP) || (rx_data == `CHAR_R_LO);
	assign is_write_cmd = (rx_data == `CHAR_W_UP) || (rx_data == `CHAR_W_LO);

	//------------------------------
	// line state machine
	//------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= ps_idle;
		else if (new_rx_data)
		begin
			case (state)
				// command letter, blank lines stay here
				ps_idle:
					if (is_write_cmd)
						state <= ps_white_data;
					else if (is_read_cmd)
						state <= ps_white_addr;
					else if (!is_eol)
						state <= ps_wait_eol;
				// separators before the data field
				ps_white_data:
					if (is_hex)
						state <= ps_data;
					else if (is_eol)
						state <= ps_idle;
					else if (!is_white)
						state <= ps_wait_eol;
				// data digits until a separator
				ps_data:
					if (is_white)
						state <= ps_white_addr;
					else if (is_eol)
						state <= ps_idle;
					else if (!is_hex)
						state <= ps_wait_eol;
				// separators before the address field
				ps_white_addr:
					if (is_hex)
						state <= ps_addr;
					else if (is_eol)
						state <= ps_idle;
					else if (!is_white)
						state <= ps_wait_eol;
				// address digits, line end issues the command
				ps_addr:
					if (is_eol)
						state <= ps_idle;
					else if (!is_hex)
						state <= ps_wait_eol;
				// drop the rest of a bad line
				ps_wait_eol:
					if (is_eol)
						state <= ps_idle;
				default:
					state <= ps_idle;
			endcase
		end
	end

	// read or write, decided by the command letter
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			write_op <= 1'b0;
		else if (new_rx_data && (state == ps_idle) && (is_write_cmd || is_read_cmd))
			write_op <= is_write_cmd;
	end

	// one cycle strobe on the line end of a complete command
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= new_rx_data && (state == ps_addr) && is_eol;
	end

	//------------------------------
	// field accumulators
	//------------------------------
	// digits shift in from the right so only the last ones survive
	always_ff @(posedge clock)
	begin
		if (new_rx_data)
		begin
			// read lines carry no data, start from zero
			if ((state == ps_idle) && (is_write_cmd || is_read_cmd))
				data_acc <= '0;
			else if (((state == ps_white_data) || (state == ps_data)) && is_hex)
				data_acc <= {data_acc[3:0], rx_nib};

			if ((state == ps_white_addr) && is_hex)
				addr_acc <= bus_addr_t'(rx_nib);
			else if ((state == ps_addr) && is_hex)
				addr_acc <= (addr_acc << 4) | bus_addr_t'(rx_nib);

			// command register loads together with the strobe
			if ((state == ps_addr) && is_eol)
			begin
				cmd.write <= write_op;
				cmd.address <= addr_acc;
				cmd.data <= data_acc;
			end
		end
	end

endmodule

// File: source/bus_master.sv
//------------------------------
// bus master
// req/gnt sequencer to the register file with read capture
//------------------------------
`timescale 1ns/1ns

module bus_master
(
	input	logic					clock,
	input	logic					reset,
	input	parser_pkg::bus_cmd_t	cmd,
	input	logic					cmd_valid,
	output	parser_pkg::bus_addr_t	int_address,
	output	parser_pkg::bus_data_t	int_wr_data,
	output	logic					int_write,
	output	logic					int_read,
	output	logic					int_req,
	input	logic					int_gnt,
	input	parser_pkg::bus_data_t	int_rd_data,
	output	parser_pkg::bus_data_t	read_data,
	output	logic					read_valid
);
	import parser_pkg::*;

	logic	write_req;
	logic	read_req;
	logic	read_done;
	logic	granted;

	// a grant only counts when no new command replaces the pending one
	assign granted = int_gnt && !cmd_valid;
	assign int_req = write_req | read_req;

	// address and write data held for the whole access
	always_ff @(posedge clock)
	begin
		if (cmd_valid)
		begin
			int_address <= cmd.address;
			int_wr_data <= cmd.data;
		end
	end

	//------------------------------
	// request flags and access pulses
	//------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			write_req <= 1'b0;
			read_req <= 1'b0;
			int_write <= 1'b0;
			int_read <= 1'b0;
		end
		else
		begin
			if (cmd_valid)
			begin
				// new command overrides whatever was waiting
				write_req <= cmd.write;
				read_req <= !cmd.write;
			end
			else if (granted)
			begin
				write_req <= 1'b0;
				read_req <= 1'b0;
			end
			// single cycle access after the sampled grant
			int_write <= write_req && granted;
			int_read <= read_req && granted;
		end
	end

	// rd data is valid the cycle after int_read, strobe it one later
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			read_done <= 1'b0;
			read_valid <= 1'b0;
		end
		else
		begin
			read_done <= int_read;
			read_valid <= read_done;
		end
	end

	always_ff @(posedge clock)
	begin
		if (read_done)
			read_data <= int_rd_data;
	end

endmodule

// File: source/reply_formatter.sv
//------------------------------
// reply formatter
// sends a read byte as two hex characters then CR LF
//------------------------------
`timescale 1ns/1ns
`include "parser_defines.svh"

module reply_formatter
(
	input	logic					clock,
	input	logic					reset,
	input	parser_pkg::bus_data_t	read_data,
	input	logic					read_valid,
	output	parser_pkg::char_t		tx_data,
	output	logic					new_tx_data,
	input	logic					tx_busy
);
	import parser_pkg::*;

	tx_state_t	state;
	bus_data_t	tx_byte;
	logic		busy_d;
	logic		tx_end;
	logic		send;
	char_t		next_char;

	// end of a character is the falling edge of tx_busy
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			busy_d <= 1'b0;
		else
			busy_d <= tx_busy;
	end

	assign tx_end = !tx_busy && busy_d;

	// start on a read, continue after each finished character
	always_comb
	begin
		send = 1'b0;
		next_char = `CHAR_LF;
		case (state)
			tx_idle:
			begin
				// tx_byte is loaded on this same edge, use the input
				send = read_valid;
				next_char = nibble_to_hex(read_data[7:4]);
			end
			tx_hi_nib:
			begin
				send = tx_end;
				next_char = nibble_to_hex(tx_byte[3:0]);
			end
			tx_lo_nib:
			begin
				send = tx_end;
				next_char = `CHAR_CR;
			end
			tx_cr:
			begin
				send = tx_end;
				next_char = `CHAR_LF;
			end
			default:
				send = 1'b0;
		endcase
	end

	//------------------------------
	// transmit state machine
	//------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= tx_idle;
			new_tx_data <= 1'b0;
		end
		else
		begin
			new_tx_data <= send;
			case (state)
				tx_idle:
					if (read_valid)
						state <= tx_hi_nib;
				tx_hi_nib:
					if (tx_end)
						state <= tx_lo_nib;
				tx_lo_nib:
					if (tx_end)
						state <= tx_cr;
				tx_cr:
					if (tx_end)
						state <= tx_lf;
				// last character, wait for it to leave
				tx_lf:
					if (tx_end)
						state <= tx_idle;
				default:
					state <= tx_idle;
			endcase
		end
	end

	// byte latch and outgoing character
	always_ff @(posedge clock)
	begin
		if ((state == tx_idle) && read_valid)
			tx_byte <= read_data;
		if (send)
			tx_data <= next_char;
	end

endmodule

// File: source/uart_parser.sv
//------------------------------
// uart parser top level
// text commands from the uart to register file accesses
//------------------------------
`timescale 1ns/1ns

module uart_parser
(
	input	logic					clock,
	input	logic					reset,
	// uart receiver
	input	parser_pkg::char_t		rx_data,
	input	logic					new_rx_data,
	// uart transmitter
	output	parser_pkg::char_t		tx_data,
	output	logic					new_tx_data,
	input	logic					tx_busy,
	// register file bus
	output	parser_pkg::bus_addr_t	int_address,
	output	parser_pkg::bus_data_t	int_wr_data,
	output	logic					int_write,
	output	logic					int_read,
	input	parser_pkg::bus_data_t	int_rd_data,
	output	logic					int_req,
	input	logic					int_gnt
);
	import parser_pkg::*;

	// decoder to bus master
	bus_cmd_t	cmd;
	logic		cmd_valid;
	// bus master to formatter
	bus_data_t	read_data;
	logic		read_valid;

	command_decoder decoder0
	(
		.clock			(clock),
		.reset			(reset),
		.rx_data		(rx_data),
		.new_rx_data	(new_rx_data),
		.cmd			(cmd),
		.cmd_valid		(cmd_valid)
	);

	bus_master master0
	(
		.clock			(clock),
		.reset			(reset),
		.cmd			(cmd),
		.cmd_valid		(cmd_valid),
		.int_address	(int_address),
		.int_wr_data	(int_wr_data),
		.int_write		(int_write),
		.int_read		(int_read),
		.int_req		(int_req),
		.int_gnt		(int_gnt),
		.int_rd_data	(int_rd_data),
		.read_data		(read_data),
		.read_valid		(read_valid)
	);

	reply_formatter formatter0
	(
		.clock			(clock),
		.reset			(reset),
		.read_data		(read_data),
		.read_valid		(read_valid),
		.tx_data		(tx_data),
		.new_tx_data	(new_tx_data),
		.tx_busy		(tx_busy)
	);

endmodule

// File: verif/uart_parser_props.sv
//------------------------------
// uart parser bus and transmit properties
//------------------------------
`timescale 1ns/1ns

module uart_parser_props
(
	input	logic	clock,
	input	logic	reset,
	input	logic	new_rx_data,
	input	logic	int_write,
	input	logic	int_read,
	input	logic	int_req,
	input	logic	int_gnt,
	input	logic	new_tx_data
);

	logic	rx_seen;

	// set by the first received character after reset
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			rx_seen <= 1'b0;
		else if (new_rx_data)
			rx_seen <= 1'b1;
	end

	// one access kind at a time
	write_read_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(int_write && int_read))
		else $error("int_write and int_read are high together");

	// access only right after a sampled grant of a pending request
	access_after_grant: assert property (@(posedge clock) disable iff (reset)
		(int_write || int_read) |-> $past(int_req && int_gnt))
		else $error("access pulse without int_req and int_gnt in the cycle before");

	// each character strobe lasts one cycle
	tx_strobe_single: assert property (@(posedge clock) disable iff (reset)
		new_tx_data |=> !new_tx_data)
		else $error("new_tx_data high for more than one cycle");

	// nothing leaves the parser after reset until a character comes in
	quiet_until_rx: assert property (@(posedge clock)
		!rx_seen |-> !(new_tx_data || int_req || int_write || int_read))
		else $error("control output high before any received character");

endmodule

bind uart_parser uart_parser_props props0
(
	.clock			(clock),
	.reset			(reset),
	.new_rx_data	(new_rx_data),
	.int_write		(int_write),
	.int_read		(int_read),
	.int_req		(int_req),
	.int_gnt		(int_gnt),
	.new_tx_data	(new_tx_data)
);

// File: verif/uart_parser_tb.sv
//------------------------------
// uart parser testbench
// random text lines against uart and register file models
//------------------------------
`timescale 1ns/1ns
`include "parser_defines.svh"

module uart_parser_tb;
	import parser_pkg::*;

	localparam int NUM_TESTS = 40;
	// limit for any single wait, in cycles
	localparam int TIMEOUT = 500;
	localparam int NUM_REGS = 1 << `PARSER_ADDR_W;

	logic		clock = 1'b0;
	logic		reset = 1'b1;
	char_t		rx_data = 8'h00;
	logic		new_rx_data = 1'b0;
	char_t		tx_data;
	logic		new_tx_data;
	logic		tx_busy = 1'b0;
	bus_addr_t	int_address;
	bus_data_t	int_wr_data;
	logic		int_write;
	logic		int_read;
	bus_data_t	int_rd_data = 8'h00;
	logic		int_req;
	logic		int_gnt = 1'b0;

	// stimulus
	logic [31:0]	lfsr = 32'd76438;
	char_t			line_q[$];
	int				gnt_delay = 0;
	int				busy_len [0:3] = '{2, 2, 2, 2};

	// register file model
	bus_data_t		regs [0:NUM_REGS-1];
	bus_data_t		exp_regs [0:NUM_REGS-1];
	bus_addr_t		last_addr = '0;
	bus_data_t		last_wr_data = '0;
	bus_addr_t		rd_addr = '0;
	logic			rd_pend = 1'b0;
	int				write_count = 0;
	int				read_count = 0;
	int				req_count = 0;
	int				gnt_wait = 0;
	logic			req_d = 1'b0;
	int				reg_errors = 0;

	// transmitter model
	char_t			tx_log [0:1023];
	int				tx_count = 0;
	int				busy_cnt = 0;
	int				tx_errors = 0;

	int				errors = 0;
	int				failed = 0;
	int				tx_rd = 0;

	uart_parser dut0
	(
		.clock			(clock),
		.reset			(reset),
		.rx_data		(rx_data),
		.new_rx_data	(new_rx_data),
		.tx_data		(tx_data),
		.new_tx_data	(new_tx_data),
		.tx_busy		(tx_busy),
		.int_address	(int_address),
		.int_wr_data	(int_wr_data),
		.int_write		(int_write),
		.int_read		(int_read),
		.int_rd_data	(int_rd_data),
		.int_req		(int_req),
		.int_gnt		(int_gnt)
	);

	// 40 ns period
	always #20 clock = ~clock;

	//------------------------------
	// random numbers and line building
	//------------------------------
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic int unsigned draw(input int nbits);
		int unsigned v;
		v = 0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr = galois_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// ascii hex digit, letters in either case
	function automatic char_t hex_char(input nibble_t n, input logic lower);
		if (n < 4'd10)
			return 8'h30 + {4'h0, n};
		else if (lower)
			return 8'h61 + {4'h0, n} - 8'd10;
		else
			return 8'h41 + {4'h0, n} - 8'd10;
	endfunction

	// startup contents, uses every address bit
	function automatic bus_data_t fill_value(input int a);
		return {a[3:0], a[7:4]} ^ a[15:8] ^ 8'h3c;
	endfunction

	// 1 to 3 spaces or tabs
	function automatic void add_sep();
		int unsigned n;
		n = 1 + draw(2) % 3;
		repeat (n)
			line_q.push_back((draw(1) != 0) ? `CHAR_TAB : `CHAR_SPACE);
	endfunction

	// up to 2 junk leading digits, then the real ones
	function automatic void add_field(input logic [31:0] value, input int digits);
		int unsigned extra;
		nibble_t nib;
		logic low;
		extra = draw(2) % 3;
		for (int i = 0; i < int'(extra) + digits; i++)
		begin
			nib = (i < int'(extra)) ? 4'(draw(4)) : 4'(value >> (4 * (int'(extra) + digits - 1 - i)));
			low = draw(1) != 0;
			line_q.push_back(hex_char(nib, low));
		end
	endfunction

	// CR, LF or CR LF
	function automatic void add_eol();
		int unsigned e;
		e = draw(2) % 3;
		if (e != 1)
			line_q.push_back(`CHAR_CR);
		if (e != 0)
			line_q.push_back(`CHAR_LF);
	endfunction

	function automatic int error_total();
		return errors + reg_errors + tx_errors;
	endfunction

	//------------------------------
	// compare tasks
	//------------------------------
	task automatic check_addr(input string name, input bus_addr_t got, input bus_addr_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_char(input string name, input char_t got, input char_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic fail(input string what);
		errors++;
		$display("%0t: %s", $time, what);
	endtask

	task automatic report(input int t, input string name, input int err0);
		if (error_total() != err0)
			failed++;
		$display("test %0d %s %s", t, name, (error_total() == err0) ? "ok" : "failed");
	endtask

	//------------------------------
	// uart receiver model
	//------------------------------
	task automatic send_line();
		int unsigned gap;
		while (line_q.size() > 0)
		begin
			rx_data = line_q.pop_front();
			new_rx_data = 1'b1;
			@(negedge clock);
			new_rx_data = 1'b0;
			gap = draw(2);
			repeat (gap) @(negedge clock);
		end
	endtask

	//------------------------------
	// register file model
	//------------------------------
	always @(negedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i[`PARSER_ADDR_W-1:0]] = fill_value(i);
			int_gnt = 1'b0;
			req_d = 1'b0;
			rd_pend = 1'b0;
		end
		else
		begin
			// int_gnt still holds the value the DUT sampled
			if ((int_write || int_read) && !int_gnt)
			begin
				reg_errors++;
				$display("%0t: access pulse without a grant", $time);
			end
			if (int_write)
			begin
				regs[int_address] = int_wr_data;
				write_count++;
				last_addr = int_address;
				last_wr_data = int_wr_data;
			end
			if (int_read)
			begin
				rd_addr = int_address;
				read_count++;
				last_addr = int_address;
			end
			// read data is only valid in the cycle after int_read
			int_rd_data = rd_pend ? regs[rd_addr] : ~regs[rd_addr];
			rd_pend = int_read;
			if (int_req && !req_d)
				req_count++;
			if (!int_req && req_d && !int_gnt)
			begin
				reg_errors++;
				$display("%0t: int_req dropped before the grant", $time);
			end
			req_d = int_req;
			// grant after gnt_delay cycles of request
			if (!int_req)
			begin
				int_gnt = 1'b0;
				gnt_wait = gnt_delay;
			end
			else if (gnt_wait == 0)
				int_gnt = 1'b1;
			else
				gnt_wait--;
		end
	end

	//------------------------------
	// uart transmitter model
	//------------------------------
	always @(negedge clock)
	begin
		if (reset)
		begin
			tx_busy = 1'b0;
			busy_cnt = 0;
		end
		else if (new_tx_data)
		begin
			if (tx_busy)
			begin
				tx_errors++;
				$display("%0t: new character while tx_busy is high", $time);
			end
			tx_log[tx_count[9:0]] = tx_data;
			busy_cnt = busy_len[tx_count[1:0]];
			tx_count++;
			tx_busy = 1'b1;
		end
		else if (tx_busy)
		begin
			busy_cnt--;
			if (busy_cnt == 0)
				tx_busy = 1'b0;
		end
	end

	//------------------------------
	// test sequences
	//------------------------------
	// one well formed read or write line
	task automatic run_command(input logic is_write);
		bus_addr_t		addr;
		bus_data_t		data;
		char_t			exp_reply [0:3];
		int unsigned	r;
		int				w0;
		int				r0;
		int				req0;
		int				idx;
		int				cycles;
		r = draw(32);
		addr = r[`PARSER_ADDR_W-1:0];
		data = r[31:24];
		gnt_delay = draw(3) % 6;
		for (int i = 0; i < 4; i++)
			busy_len[i[1:0]] = 2 + draw(3) % 7;
		w0 = write_count;
		r0 = read_count;
		req0 = req_count;
		if (is_write)
			line_q.push_back((draw(1) != 0) ? `CHAR_W_UP : `CHAR_W_LO);
		else
			line_q.push_back((draw(1) != 0) ? `CHAR_R_UP : `CHAR_R_LO);
		add_sep();
		if (is_write)
		begin
			add_field(32'(data), 2);
			add_sep();
		end
		add_field(32'(addr), `PARSER_ADDR_W / 4);
		add_eol();
		send_line();
		cycles = 0;
		while ((write_count == w0) && (read_count == r0) && (cycles < TIMEOUT))
		begin
			@(negedge clock);
			cycles++;
		end
		if ((write_count == w0) && (read_count == r0))
		begin
			fail("timeout waiting for int_write or int_read");
			return;
		end
		// room for a second, unwanted pulse
		repeat (4) @(negedge clock);
		if ((write_count - w0 != (is_write ? 1 : 0)) || (read_count - r0 != (is_write ? 0 : 1)))
			fail("wrong number or kind of access pulses");
		if (req_count - req0 != 1)
			fail("expected exactly one int_req");
		check_addr("int_address", last_addr, addr);
		if (is_write)
		begin
			check_data("int_wr_data", last_wr_data, data);
			exp_regs[addr] = data;
			return;
		end
		// reply is the stored byte in upper case hex, then CR LF
		exp_reply[0] = hex_char(exp_regs[addr][7:4], 1'b0);
		exp_reply[1] = hex_char(exp_regs[addr][3:0], 1'b0);
		exp_reply[2] = `CHAR_CR;
		exp_reply[3] = `CHAR_LF;
		cycles = 0;
		while ((tx_count < tx_rd + 4) && (cycles < TIMEOUT))
		begin
			@(negedge clock);
			cycles++;
		end
		if (tx_count < tx_rd + 4)
		begin
			fail("timeout waiting for the four reply characters");
			return;
		end
		for (int i = 0; i < 4; i++)
		begin
			idx = tx_rd + i;
			check_char("tx_data", tx_log[idx[9:0]], exp_reply[i[1:0]]);
		end
		tx_rd += 4;
		cycles = 0;
		while (tx_busy && (cycles < TIMEOUT))
		begin
			@(negedge clock);
			cycles++;
		end
		if (tx_busy)
			fail("timeout waiting for tx_busy to fall after the reply");
		repeat (2) @(negedge clock);
	endtask

	// lines that must be dropped without bus or uart activity
	task automatic run_malformed();
		int unsigned	kind;
		int				req0;
		kind = draw(2);
		req0 = req_count;
		case (kind)
			// unknown command letter
			0:
			begin
				line_q.push_back(8'h71);
				add_sep();
				add_field(draw(8), 2);
			end
			// write with no address field
			1:
			begin
				line_q.push_back(`CHAR_W_LO);
				add_sep();
				add_field(draw(8), 2);
			end
			// address ends in a 'g'
			2:
			begin
				line_q.push_back(`CHAR_R_UP);
				add_sep();
				add_field(draw(4), 1);
				line_q.push_back(8'h67);
			end
			// blank line
			default:
				line_q.delete();
		endcase
		add_eol();
		send_line();
		repeat (16) @(negedge clock);
		if (req_count != req0)
			fail("int_req raised for a malformed line");
		if (tx_count != tx_rd)
			fail("reply sent for a malformed line");
	endtask

	initial
	begin
		int				err0;
		int unsigned	kind;
		for (int i = 0; i < NUM_REGS; i++)
			exp_regs[i[`PARSER_ADDR_W-1:0]] = fill_value(i);

		// quiet outputs through reset and the idle cycles after it
		err0 = error_total();
		for (int i = 0; i < 20; i++)
		begin
			@(negedge clock);
			check_flag("new_tx_data", new_tx_data, 1'b0);
			check_flag("int_req", int_req, 1'b0);
			check_flag("int_write", int_write, 1'b0);
			check_flag("int_read", int_read, 1'b0);
			if (i == 9)
				reset = 1'b0;
		end
		report(0, "reset", err0);

		for (int t = 1; t <= NUM_TESTS; t++)
		begin
			err0 = error_total();
			kind = draw(3);
			if (kind < 3)
			begin
				run_command(1'b1);
				report(t, "write", err0);
			end
			else if (kind < 6)
			begin
				run_command(1'b0);
				report(t, "read", err0);
			end
			else
			begin
				run_malformed();
				report(t, "malformed", err0);
			end
		end

		// register file against the reference contents
		err0 = error_total();
		for (int i = 0; i < NUM_REGS; i++)
			check_data($sformatf("regs[%0h]", i), regs[i[`PARSER_ADDR_W-1:0]],
				exp_regs[i[`PARSER_ADDR_W-1:0]]);
		report(NUM_TESTS + 1, "register contents", err0);

		$display("%0d tests, %0d failed, %0d errors", NUM_TESTS + 2, failed, error_total());
		if (error_total() == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// backstop, 50000 cycles
	initial
	begin
		#2000000;
		$display("run did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+source
source/parser_pkg.sv
source/command_decoder.sv
source/bus_master.sv
source/reply_formatter.sv
source/uart_parser.sv
verif/uart_parser_props.sv
verif/uart_parser_tb.sv

// File: Makefile
TOP = uart_parser_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
